// ==== src/stm_macros.svh ====
// shared constants; the queue depth must be a power of two and the delay at least one cycle
`ifndef STM_MACROS_SVH
`define STM_MACROS_SVH

// widths of the trace event fields
`define STM_TIMESTAMP_WIDTH 32
`define STM_REG_WIDTH 32
`define STM_TRACE_ID_WIDTH 16

// debug noc flit layout
`define STM_FLIT_TYPE_WIDTH 2
`define STM_FLIT_CONTENT_WIDTH 16
`define STM_DEST_WIDTH 5
`define STM_CLASS_WIDTH 4
`define STM_CLASS_STM 4'h2

// event path sizing
`define STM_TRIGGER_DELAY 2
`define STM_QUEUE_DEPTH 8
`define STM_FLITS_PER_EVENT 7

// marker nop: l.nop with the immediate as trace id
`define STM_NOP_OPCODE 6'h05
`define STM_NOP_SUBOP 2'b01
`define STM_TRACE_REG 5'd3

`endif

// ==== src/stm_trace_pkg.sv ====
// core trace port and trace event types; field widths follow stm_macros.svh
`default_nettype none

`include "stm_macros.svh"

package stm_trace_pkg;

   // global timestamp from the timestamp provider
   typedef logic [`STM_TIMESTAMP_WIDTH-1:0] timestamp_t;

   // one general purpose register value
   typedef logic [`STM_REG_WIDTH-1:0] reg_data_t;

   // immediate of the marker nop
   typedef logic [`STM_TRACE_ID_WIDTH-1:0] trace_id_t;

   // writeback stage signals of the traced core, 71 bits
   typedef struct packed {
      logic [4:0] rf_addrw;
      reg_data_t  rf_dataw;
      logic       rf_we;
      logic       wb_freeze;
      logic [31:0] wb_insn;
   } trace_port_t;

   // one recorded trace point, 80 bits
   typedef struct packed {
      timestamp_t timestamp;
      reg_data_t  value;
      trace_id_t  id;
   } trace_event_t;

endpackage

`default_nettype wire

// ==== src/stm_noc_pkg.sv ====
// debug noc flit and packetizer types; single virtual channel, 16-bit flit content only
`default_nettype none

`include "stm_macros.svh"

package stm_noc_pkg;

   // flit type encoding as used on the debug noc
   typedef enum logic [`STM_FLIT_TYPE_WIDTH-1:0] {
      PAYLOAD = 2'b00,
      HEAD    = 2'b01,
      LAST    = 2'b10
   } flit_type_t;

   // payload part of a flit
   typedef logic [`STM_FLIT_CONTENT_WIDTH-1:0] flit_content_t;

   // complete flit, 18 bits
   typedef struct packed {
      flit_type_t    ftype;
      flit_content_t content;
   } flit_t;

   // packetizer states
   typedef enum logic {
      IDLE = 1'b0,
      SEND = 1'b1
   } pkt_state_t;

endpackage

`default_nettype wire

// ==== src/stm_trace_collector.sv ====
// records marker nops at writeback; an r3 write in the same cycle as the marker is not seen
`timescale 1ns/1ns
`default_nettype none

`include "stm_macros.svh"

module stm_trace_collector (
   input  wire logic                       clk,
   input  wire logic                       reset,
   input  wire stm_trace_pkg::trace_port_t trace_port,
   input  wire logic                       halted,
   input  wire stm_trace_pkg::timestamp_t  timestamp,
   output stm_trace_pkg::trace_event_t     trace_out,
   output logic                            trace_valid
);

   // shadow copy of the traced register
   stm_trace_pkg::reg_data_t shadow_r3;

   // trace id carried in the nop immediate
   stm_trace_pkg::trace_id_t nop_imm;

   logic is_marker;
   logic id_nonzero;
   logic core_active;
   logic record;
   logic r3_write;

   assign nop_imm = trace_port.wb_insn[15:0];

   // opcode and sub-opcode of the marker nop
   assign is_marker = (trace_port.wb_insn[31:26] == `STM_NOP_OPCODE) &&
                      (trace_port.wb_insn[25:24] == `STM_NOP_SUBOP);

   // id zero is an ordinary nop
   assign id_nonzero = (nop_imm != '0);

   // frozen writeback or halted core means the insn is not retiring
   assign core_active = !trace_port.wb_freeze && !halted;

   assign record = is_marker && id_nonzero && core_active;

   assign r3_write = trace_port.rf_we && (trace_port.rf_addrw == `STM_TRACE_REG);

   // track r3 from register file writes
   always_ff @(posedge clk) begin
      if (reset) begin
         shadow_r3 <= '0;
      end else if (r3_write) begin
         shadow_r3 <= trace_port.rf_dataw;
      end
   end

   // one cycle valid pulse per recorded marker
   always_ff @(posedge clk) begin
      if (reset) begin
         trace_valid <= 1'b0;
      end else begin
         trace_valid <= record;
      end
   end

   // event payload, old r3 value on purpose
   always_ff @(posedge clk) begin
      if (record) begin
         trace_out.timestamp <= timestamp;
         trace_out.value     <= shadow_r3;
         trace_out.id        <= nop_imm;
      end
   end

endmodule

`default_nettype wire

// ==== src/stm_data_sr.sv ====
// fixed delay line; bit 0 of din is the valid bit, DELAY_CYCLES must be at least 1
`timescale 1ns/1ns
`default_nettype none

module stm_data_sr #(
   parameter int DELAY_CYCLES = 2,
   parameter int DATA_WIDTH   = 81
) (
   input  wire logic                  clk,
   input  wire logic                  reset,
   input  wire logic [DATA_WIDTH-1:0] din,
   output logic      [DATA_WIDTH-1:0] dout
);

   // stage 0 takes din, last stage drives dout
   logic [DATA_WIDTH-1:0] stage [DELAY_CYCLES];

   always_ff @(posedge clk) begin
      stage[0] <= din;
      for (int i = 1; i < DELAY_CYCLES; i++) begin
         stage[i] <= stage[i-1];
      end
      // only the valid bits need clearing
      if (reset) begin
         for (int i = 0; i < DELAY_CYCLES; i++) begin
            stage[i][0] <= 1'b0;
         end
      end
   end

   assign dout = stage[DELAY_CYCLES-1];

endmodule

`default_nettype wire

// ==== src/stm_dbgnoc_if.sv ====
// event queue and packetizer; one vc, outbound only, upstream must stop when disable is high
`timescale 1ns/1ns
`default_nettype none

`include "stm_macros.svh"

module stm_dbgnoc_if #(
   parameter int CORE_ID = 0
) (
   input  wire logic                         clk,
   input  wire logic                         reset,
   input  wire stm_trace_pkg::trace_event_t  trace_in,
   input  wire logic                         trace_in_valid,
   output stm_noc_pkg::flit_t                dbgnoc_out_flit,
   output logic                              dbgnoc_out_valid,
   input  wire logic                         dbgnoc_out_ready,
   output logic                              sys_clk_disable
);

   localparam int DEPTH      = `STM_QUEUE_DEPTH;
   localparam int PTR_WIDTH  = $clog2(DEPTH);
   localparam int CNT_WIDTH  = $clog2(DEPTH + 1);
   localparam int IDX_WIDTH  = $clog2(`STM_FLITS_PER_EVENT);
   // free entries must cover collector plus delay line
   localparam int DISABLE_LEVEL = DEPTH - `STM_TRIGGER_DELAY - 1;
   localparam int PAD_WIDTH  = `STM_FLIT_CONTENT_WIDTH - `STM_DEST_WIDTH - `STM_CLASS_WIDTH;

   // circular event storage
   stm_trace_pkg::trace_event_t queue_mem [DEPTH];
   logic [PTR_WIDTH-1:0] wr_ptr;
   logic [PTR_WIDTH-1:0] rd_ptr;
   logic [CNT_WIDTH-1:0] queue_count;
   logic [CNT_WIDTH-1:0] queue_count_next;

   // packetizer
   stm_noc_pkg::pkt_state_t     state;
   logic [IDX_WIDTH-1:0]        flit_idx;
   stm_trace_pkg::trace_event_t cur_event;

   logic push;
   logic pop;
   logic xfer;
   logic last_flit;

   assign push = trace_in_valid;
   // start a packet only from idle
   assign pop  = (state == stm_noc_pkg::IDLE) && (queue_count != '0);
   assign xfer = dbgnoc_out_valid && dbgnoc_out_ready;
   assign last_flit = (flit_idx == IDX_WIDTH'(`STM_FLITS_PER_EVENT - 1));

   always_comb begin
      queue_count_next = queue_count;
      if (push && !pop) begin
         queue_count_next = queue_count + 1'b1;
      end else if (!push && pop) begin
         queue_count_next = queue_count - 1'b1;
      end
   end

   // queue storage, no reset needed
   always_ff @(posedge clk) begin
      if (push) begin
         queue_mem[wr_ptr] <= trace_in;
      end
   end

   // pointers, fill level and halt request
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr          <= '0;
         rd_ptr          <= '0;
         queue_count     <= '0;
         sys_clk_disable <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         queue_count     <= queue_count_next;
         sys_clk_disable <= (queue_count_next >= CNT_WIDTH'(DISABLE_LEVEL));
      end
   end

   // packet fsm, index moves only on a transfer
   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= stm_noc_pkg::IDLE;
         flit_idx <= '0;
      end else begin
         case (state)
            stm_noc_pkg::IDLE: begin
               if (pop) begin
                  state    <= stm_noc_pkg::SEND;
                  flit_idx <= '0;
               end
            end
            stm_noc_pkg::SEND: begin
               if (xfer) begin
                  if (last_flit) begin
                     state <= stm_noc_pkg::IDLE;
                  end
                  flit_idx <= flit_idx + 1'b1;
               end
            end
            default: state <= stm_noc_pkg::IDLE;
         endcase
      end
   end

   // event held for the whole packet
   always_ff @(posedge clk) begin
      if (pop) begin
         cur_event <= queue_mem[rd_ptr];
      end
   end

   assign dbgnoc_out_valid = (state == stm_noc_pkg::SEND);

   // flit content by index
   always_comb begin
      dbgnoc_out_flit.ftype = stm_noc_pkg::PAYLOAD;
      case (flit_idx)
         3'd0: begin
            dbgnoc_out_flit.ftype   = stm_noc_pkg::HEAD;
            // destination 0 is the host
            dbgnoc_out_flit.content = {{`STM_DEST_WIDTH{1'b0}}, {PAD_WIDTH{1'b0}},
                                       `STM_CLASS_STM};
         end
         3'd1: dbgnoc_out_flit.content = 16'(CORE_ID);
         3'd2: dbgnoc_out_flit.content = cur_event.timestamp[31:16];
         3'd3: dbgnoc_out_flit.content = cur_event.timestamp[15:0];
         3'd4: dbgnoc_out_flit.content = cur_event.value[31:16];
         3'd5: dbgnoc_out_flit.content = cur_event.value[15:0];
         default: begin
            dbgnoc_out_flit.ftype   = stm_noc_pkg::LAST;
            dbgnoc_out_flit.content = cur_event.id;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== src/stm.sv ====
// software trace module top; single core, outbound debug noc only, no clock domain crossing
`timescale 1ns/1ns
`default_nettype none

`include "stm_macros.svh"

module stm #(
   parameter int CORE_ID = 0
) (
   input  wire logic                       clk,
   input  wire logic                       reset,
   // global timestamp
   input  wire stm_trace_pkg::timestamp_t  timestamp,
   // writeback signals of the traced core
   input  wire stm_trace_pkg::trace_port_t trace_port,
   // debug noc output
   output stm_noc_pkg::flit_t              dbgnoc_out_flit,
   output logic                            dbgnoc_out_valid,
   input  wire logic                       dbgnoc_out_ready,
   // system control
   output logic                            sys_clk_disable,
   input  wire logic                       sys_clk_is_halted
);

   // event plus valid bit through the delay line
   localparam int SR_WIDTH = $bits(stm_trace_pkg::trace_event_t) + 1;

   stm_trace_pkg::trace_event_t trace;
   logic                        trace_valid;
   stm_trace_pkg::trace_event_t trace_delayed;
   logic                        trace_delayed_valid;

   stm_trace_collector u_trace_collector (
      .clk         (clk),
      .reset       (reset),
      .trace_port  (trace_port),
      .halted      (sys_clk_is_halted),
      .timestamp   (timestamp),
      .trace_out   (trace),
      .trace_valid (trace_valid)
   );

   // aligns events with the trigger window
   stm_data_sr #(
      .DELAY_CYCLES (`STM_TRIGGER_DELAY),
      .DATA_WIDTH   (SR_WIDTH)
   ) u_data_sr (
      .clk   (clk),
      .reset (reset),
      .din   ({trace, trace_valid}),
      .dout  ({trace_delayed, trace_delayed_valid})
   );

   stm_dbgnoc_if #(
      .CORE_ID (CORE_ID)
   ) u_dbgnoc_if (
      .clk              (clk),
      .reset            (reset),
      .trace_in         (trace_delayed),
      .trace_in_valid   (trace_delayed_valid),
      .dbgnoc_out_flit  (dbgnoc_out_flit),
      .dbgnoc_out_valid (dbgnoc_out_valid),
      .dbgnoc_out_ready (dbgnoc_out_ready),
      .sys_clk_disable  (sys_clk_disable)
   );

endmodule

`default_nettype wire

// ==== tests/stm_sva.sv ====
// bound into stm; the fill-level check reaches into u_dbgnoc_if.queue_count
`timescale 1ns/1ns
`default_nettype none

`include "stm_macros.svh"

module stm_sva (
   input wire logic                                    clk,
   input wire logic                                    reset,
   input wire stm_noc_pkg::flit_t                      dbgnoc_out_flit,
   input wire logic                                    dbgnoc_out_valid,
   input wire logic                                    dbgnoc_out_ready,
   input wire logic                                    sys_clk_disable,
   input wire logic                                    trace_delayed_valid,
   input wire logic [$clog2(`STM_QUEUE_DEPTH+1)-1:0]   queue_count
);

   // stalled flit holds until it transfers
   stall_hold: assert property (@(posedge clk) disable iff (reset)
      dbgnoc_out_valid && !dbgnoc_out_ready |=> dbgnoc_out_valid && $stable(dbgnoc_out_flit))
      else $error("flit dropped or changed while stalled");

   // control outputs quiet right after reset
   reset_quiet: assert property (@(posedge clk)
      reset |=> !dbgnoc_out_valid && !sys_clk_disable)
      else $error("control output high in the cycle after reset");

   // a full queue has stopped the core and takes an event only while a packet starts
   full_disables: assert property (@(posedge clk) disable iff (reset)
      queue_count == `STM_QUEUE_DEPTH |->
         sys_clk_disable && (!trace_delayed_valid || !dbgnoc_out_valid))
      else $error("queue full while sys_clk_disable is low or an event is lost");

endmodule

bind stm stm_sva u_stm_sva (
   .clk                 (clk),
   .reset               (reset),
   .dbgnoc_out_flit     (dbgnoc_out_flit),
   .dbgnoc_out_valid    (dbgnoc_out_valid),
   .dbgnoc_out_ready    (dbgnoc_out_ready),
   .sys_clk_disable     (sys_clk_disable),
   .trace_delayed_valid (trace_delayed_valid),
   .queue_count         (u_dbgnoc_if.queue_count)
);

`default_nettype wire

// ==== tests/stm_checker.sv ====
// reference model of the marker rule; assumes the DUT queue is empty whenever reset is high
`timescale 1ns/1ns
`default_nettype none

`include "stm_macros.svh"

module stm_checker #(
   parameter int CORE_ID = 0
) (
   input  wire logic                       clk,
   input  wire logic                       reset,
   input  wire stm_trace_pkg::timestamp_t  timestamp,
   input  wire stm_trace_pkg::trace_port_t trace_port,
   input  wire logic                       sys_clk_is_halted,
   input  wire stm_noc_pkg::flit_t         dbgnoc_out_flit,
   input  wire logic                       dbgnoc_out_valid,
   input  wire logic                       dbgnoc_out_ready,
   input  wire logic                       sys_clk_disable,
   input  wire logic                       test_end,
   input  wire logic [7:0]                 test_num,
   output int                              pending,
   output int                              pass_count,
   output int                              fail_count
);

   localparam int DELAY = `STM_TRIGGER_DELAY;
   localparam int DEPTH = `STM_QUEUE_DEPTH;

   // expected events, oldest first
   stm_trace_pkg::trace_event_t exp_q[$];
   stm_trace_pkg::trace_event_t new_event;
   stm_trace_pkg::reg_data_t    shadow = '0;
   stm_noc_pkg::flit_t          exp_flit;
   int   flit_idx = 0;
   int   test_errors = 0;
   int   packets_done = 0;
   logic marker;

   // markers on their way to the queue, top bit is the cycle of the queue write
   logic [DELAY:0] in_flight = '0;
   // queue fill and packet in progress as the timing rules predict
   int   queue_fill = 0;
   logic busy = 1'b0;
   logic exp_disable = 1'b0;
   logic pkt_start;
   logic last_xfer;

   // marker nop, nonzero id, core retiring
   assign marker = (trace_port.wb_insn[31:26] == `STM_NOP_OPCODE) &&
                   (trace_port.wb_insn[25:24] == 2'b01) &&
                   (trace_port.wb_insn[15:0] != 16'h0000) &&
                   !trace_port.wb_freeze && !sys_clk_is_halted;

   // flit idx of the packet for one event
   function automatic stm_noc_pkg::flit_t expected_flit(
      input stm_trace_pkg::trace_event_t ev, input int idx);
      stm_noc_pkg::flit_t f;
      f.ftype   = stm_noc_pkg::PAYLOAD;
      f.content = '0;
      case (idx)
         // head: destination 0 on top, class in the low bits
         0: begin
            f.ftype   = stm_noc_pkg::HEAD;
            f.content = 16'(`STM_CLASS_STM);
         end
         1: f.content = 16'(CORE_ID);
         2: f.content = ev.timestamp[31:16];
         3: f.content = ev.timestamp[15:0];
         4: f.content = ev.value[31:16];
         5: f.content = ev.value[15:0];
         default: begin
            f.ftype   = stm_noc_pkg::LAST;
            f.content = ev.id;
         end
      endcase
      return f;
   endfunction

   initial begin
      pending    = 0;
      pass_count = 0;
      fail_count = 0;
   end

   always @(posedge clk) begin
      if (reset) begin
         exp_q.delete();
         shadow      = '0;
         flit_idx    = 0;
         in_flight   = '0;
         queue_fill  = 0;
         busy        = 1'b0;
         exp_disable = 1'b0;
      end else begin
         // valid and halt request as predicted for this cycle
         if (dbgnoc_out_valid !== busy) begin
            $display("** Error at %0t: dbgnoc_out_valid expected %b, got %b",
                     $time, busy, dbgnoc_out_valid);
            test_errors++;
         end
         if (sys_clk_disable !== exp_disable) begin
            $display("** Error at %0t: sys_clk_disable expected %b, got %b",
                     $time, exp_disable, sys_clk_disable);
            test_errors++;
         end
         last_xfer = 1'b0;
         // compare first, a new event never leaves in its own cycle
         if (dbgnoc_out_valid && dbgnoc_out_ready) begin
            if (exp_q.size() == 0) begin
               $display("test %0d: flit %h sent at %0t with no packet expected",
                        test_num, dbgnoc_out_flit, $time);
               test_errors++;
            end else begin
               exp_flit = expected_flit(exp_q[0], flit_idx);
               if (dbgnoc_out_flit !== exp_flit) begin
                  $display("** Error at %0t: dbgnoc_out_flit expected %h, got %h",
                           $time, exp_flit, dbgnoc_out_flit);
                  test_errors++;
               end
               if (flit_idx == `STM_FLITS_PER_EVENT - 1) begin
                  void'(exp_q.pop_front());
                  flit_idx = 0;
                  packets_done++;
                  last_xfer = 1'b1;
               end else begin
                  flit_idx++;
               end
            end
         end
         // a packet starts only from an idle port with something queued
         pkt_start = !busy && (queue_fill != 0);
         if (in_flight[DELAY]) begin
            queue_fill++;
         end
         if (pkt_start) begin
            queue_fill--;
         end
         // halt request while few free entries remain
         exp_disable = ((DEPTH - queue_fill) <= (DELAY + 1));
         if (pkt_start) begin
            busy = 1'b1;
         end else if (last_xfer) begin
            busy = 1'b0;
         end
         in_flight = {in_flight[DELAY-1:0], marker};
         // event takes r3 as it was before this cycle
         if (marker) begin
            new_event.timestamp = timestamp;
            new_event.value     = shadow;
            new_event.id        = trace_port.wb_insn[15:0];
            exp_q.push_back(new_event);
         end
         if (trace_port.rf_we && trace_port.rf_addrw == `STM_TRACE_REG) begin
            shadow = trace_port.rf_dataw;
         end
      end
      // one result line per test
      if (test_end) begin
         if (exp_q.size() != 0) begin
            $display("test %0d: %0d expected packets were never sent", test_num, exp_q.size());
            test_errors++;
         end
         if (test_errors == 0) begin
            $display("test %0d passed, %0d packets checked", test_num, packets_done);
            pass_count++;
         end else begin
            $display("test %0d failed with %0d errors", test_num, test_errors);
            fail_count++;
         end
         test_errors  = 0;
         packets_done = 0;
      end
      pending = exp_q.size();
   end

endmodule

`default_nettype wire

// ==== tests/tb_stm.sv ====
// top testbench; reads tests/stm_stimulus.txt from the project root, resets before each test
`timescale 1ns/1ns
`default_nettype none

`include "stm_macros.svh"

module tb_stm;

   localparam int CORE_ID      = 5;
   localparam int RESET_CYCLES = 5;
   localparam int DRAIN_CYCLES = 200;
   // quiet cycles covering collector, delay line, queue write and first flit
   localparam int SETTLE_CYCLES = `STM_TRIGGER_DELAY + 4;

   // one row of the stimulus file, one clock cycle
   typedef struct packed {
      logic [7:0]                 test;
      stm_trace_pkg::trace_port_t port;
      logic                       backpressure;
   } stim_row_t;

   logic                       clk = 1'b0;
   logic                       reset = 1'b1;
   stm_trace_pkg::timestamp_t  timestamp = 32'h00a5_fff0;
   stm_trace_pkg::trace_port_t trace_port = '0;
   logic                       dbgnoc_out_ready = 1'b1;
   logic                       sys_clk_is_halted = 1'b0;
   stm_noc_pkg::flit_t         dbgnoc_out_flit;
   logic                       dbgnoc_out_valid;
   logic                       sys_clk_disable;

   logic       bp_enable = 1'b0;
   logic       test_end = 1'b0;
   logic [7:0] test_num = '0;
   logic       loaded = 1'b0;
   int         pending;
   int         pass_count;
   int         fail_count;
   int         setup_errors = 0;
   stim_row_t  rows[$];

   always #20 clk = ~clk;

   // free running global time
   always @(posedge clk) timestamp <= timestamp + 1;

   // system halts the core one cycle after the request
   always @(posedge clk) sys_clk_is_halted <= sys_clk_disable;

   // random stalls only where the row asks
   always @(posedge clk) dbgnoc_out_ready <= bp_enable ? 1'($urandom) : 1'b1;

   stm #(.CORE_ID(CORE_ID)) u_stm (
      .clk               (clk),
      .reset             (reset),
      .timestamp         (timestamp),
      .trace_port        (trace_port),
      .dbgnoc_out_flit   (dbgnoc_out_flit),
      .dbgnoc_out_valid  (dbgnoc_out_valid),
      .dbgnoc_out_ready  (dbgnoc_out_ready),
      .sys_clk_disable   (sys_clk_disable),
      .sys_clk_is_halted (sys_clk_is_halted)
   );

   stm_checker #(.CORE_ID(CORE_ID)) u_checker (
      .clk               (clk),
      .reset             (reset),
      .timestamp         (timestamp),
      .trace_port        (trace_port),
      .sys_clk_is_halted (sys_clk_is_halted),
      .dbgnoc_out_flit   (dbgnoc_out_flit),
      .dbgnoc_out_valid  (dbgnoc_out_valid),
      .dbgnoc_out_ready  (dbgnoc_out_ready),
      .sys_clk_disable   (sys_clk_disable),
      .test_end          (test_end),
      .test_num          (test_num),
      .pending           (pending),
      .pass_count        (pass_count),
      .fail_count        (fail_count)
   );

   task automatic load_stimulus();
      int          fd;
      string       line;
      int          t;
      int          we;
      int          addr;
      int          frz;
      int          bp;
      logic [31:0] data;
      logic [31:0] insn;
      stim_row_t   row;
      fd = $fopen("tests/stm_stimulus.txt", "r");
      if (fd == 0) begin
         $display("cannot open tests/stm_stimulus.txt");
         setup_errors++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // comment and blank lines do not parse
            if ($sscanf(line, "%d %d %d %h %h %d %d",
                        t, we, addr, data, insn, frz, bp) == 7) begin
               row.test              = 8'(t);
               row.port.rf_we        = we[0];
               row.port.rf_addrw     = 5'(addr);
               row.port.rf_dataw     = data;
               row.port.wb_insn      = insn;
               row.port.wb_freeze    = frz[0];
               row.backpressure      = bp[0];
               rows.push_back(row);
            end
         end
         $fclose(fd);
      end
      loaded = 1'b1;
   endtask

   task automatic apply_reset();
      @(posedge clk);
      reset <= 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
   endtask

   // bounded wait until every expected packet is out and the event path stays quiet
   task automatic wait_drained();
      int waited;
      int quiet;
      waited = 0;
      quiet  = 0;
      while (quiet < SETTLE_CYCLES && waited < DRAIN_CYCLES) begin
         @(negedge clk);
         waited++;
         if (pending != 0 || dbgnoc_out_valid || sys_clk_disable) begin
            quiet = 0;
         end else begin
            quiet++;
         end
      end
   endtask

   task automatic close_test(input logic [7:0] num);
      @(posedge clk);
      test_num <= num;
      test_end <= 1'b1;
      @(posedge clk);
      test_end <= 1'b0;
   endtask

   initial begin
      int         idx;
      logic [7:0] cur;
      void'($urandom(32'h02f21bd2));
      load_stimulus();
      idx = 0;
      while (idx < rows.size()) begin
         cur = rows[idx].test;
         apply_reset();
         while (idx < rows.size() && rows[idx].test == cur) begin
            @(posedge clk);
            trace_port <= rows[idx].port;
            bp_enable  <= rows[idx].backpressure;
            idx++;
         end
         @(posedge clk);
         trace_port <= '0;
         wait_drained();
         close_test(cur);
      end
      @(negedge clk);
      $display("summary: %0d tests passed, %0d tests failed", pass_count,
               fail_count + setup_errors);
      if (fail_count == 0 && setup_errors == 0 && pass_count > 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

   // limit grows with the number of rows
   initial begin
      wait (loaded);
      repeat (rows.size() * 20 + 200) @(posedge clk);
      $display("watchdog expired after %0d cycles, run did not finish",
               rows.size() * 20 + 200);
      $display("Testbench failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== stm.f ====
+incdir+src
src/stm_trace_pkg.sv
src/stm_noc_pkg.sv
src/stm_trace_collector.sv
src/stm_data_sr.sv
src/stm_dbgnoc_if.sv
src/stm.sv
tests/stm_sva.sv
tests/stm_checker.sv
tests/tb_stm.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_stm
FILELIST  := stm.f
VFLAGS    := --binary --timing --assert --timescale 1ns/1ns
LINTFLAGS := --lint-only --timing --assert --timescale 1ns/1ns
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Testbench failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/stm_stimulus.txt ====
# test rf_we rf_addrw rf_dataw(hex) wb_insn(hex) wb_freeze backpressure
# one row per clock cycle, marker nop is 15000000 plus the 16-bit id
1 1 3 cafe0001 e0632000 0 0
1 0 0 00000000 15001234 0 0
2 0 0 00000000 e0632000 0 0
2 0 0 00000000 15000000 0 0
2 0 0 00000000 1500beef 1 0
2 0 0 00000000 1400beef 0 0
3 1 3 11112222 e0632000 0 0
3 1 4 33334444 e0842000 0 0
3 1 3 55556666 1500a001 0 0
3 0 0 00000000 1500a002 0 0
4 1 3 0badf00d 15000b01 0 1
4 0 0 00000000 15000b02 0 1
4 1 3 deadbeef 15000b03 0 1
4 0 0 00000000 15000b04 0 1
5 1 3 a5a5a5a5 1500c001 0 0
5 0 0 00000000 1500c002 0 0
5 0 0 00000000 1500c003 0 0
5 0 0 00000000 1500c004 0 0
5 0 0 00000000 1500c005 0 0
5 0 0 00000000 1500c006 0 0
5 0 0 00000000 1500c007 0 0
5 0 0 00000000 1500c008 0 0
5 0 0 00000000 1500c009 0 0
5 0 0 00000000 1500c00a 0 0
5 0 0 00000000 1500c00b 0 0
6 0 0 00000000 00000000 0 0
6 0 0 00000000 1500600d 0 1
